/* common/isa_pkg.sv */
package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode, inst[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_PREF    = 6'b110011
    } opcode_e;

    // function code of special, inst[5:0]
    typedef enum logic [OPCODE_W-1:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_MOVZ = 6'b001010,
        F_MOVN = 6'b001011,
        F_SYNC = 6'b001111,
        F_MFHI = 6'b010000,
        F_MTHI = 6'b010001,
        F_MFLO = 6'b010010,
        F_MTLO = 6'b010011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111
    } funct_e;

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

    localparam int ALU_OP_W  = 5;
    localparam int ALU_SEL_W = 3;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MFHI,
        ALU_MFLO,
        ALU_MTHI,
        ALU_MTLO,
        ALU_MOVN,
        ALU_MOVZ,
        ALU_ADDI,
        ALU_ADDIU
    } alu_op_e;

    // which unit produces the write-back word
    typedef enum logic [ALU_SEL_W-1:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_MOVE,
        SEL_ARITH
    } alu_sel_e;

    typedef struct packed {
        alu_op_e            alu_op;
        alu_sel_e           alu_sel;
        isa_pkg::word_t     op1;
        isa_pkg::word_t     op2;
        isa_pkg::reg_addr_t wd;    // destination register
        logic               wreg;  // write enable
    } id_ex_t;

    typedef struct packed {
        isa_pkg::reg_addr_t wd;
        logic               wreg;
        isa_pkg::word_t     wdata;
        logic               whilo; // hi/lo update
        isa_pkg::word_t     hi;
        isa_pkg::word_t     lo;
    } ex_res_t;

    typedef struct packed {
        isa_pkg::reg_addr_t wd;
        logic               wreg;
        isa_pkg::word_t     wdata;
    } wb_t;

endpackage

/* decode/instr_decode.sv */
module instr_decode (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  isa_pkg::word_t      inst_i,
    input  isa_pkg::word_t      rdata1_i,
    input  isa_pkg::word_t      rdata2_i,
    input  pipe_pkg::ex_res_t   ex_fwd_i,  // last instruction
    input  pipe_pkg::ex_res_t   mem_fwd_i, // instruction before last
    output isa_pkg::reg_addr_t  raddr1_o,
    output isa_pkg::reg_addr_t  raddr2_o,
    output logic                re1_o,
    output logic                re2_o,
    output pipe_pkg::id_ex_t    id_ex_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t     ir;
    opcode_e   op;
    funct_e    fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [SHAMT_W-1:0] sa;

    alu_op_e   alu_op;
    alu_sel_e  alu_sel;
    reg_addr_t wd;
    logic      wreg_base;
    logic      wreg;
    logic      re1;
    logic      re2;
    word_t     imm;
    word_t     op1;
    word_t     op2;

    // forward from execute first, then memory, then the register file
    function automatic word_t resolve(input logic re, input reg_addr_t addr,
                                      input word_t rdata, input word_t imm_v,
                                      input ex_res_t ex_f, input ex_res_t mem_f);
        if (!re) begin
            return imm_v;
        end else if (ex_f.wreg && ex_f.wd == addr && addr != '0) begin
            return ex_f.wdata;
        end else if (mem_f.wreg && mem_f.wd == addr && addr != '0) begin
            return mem_f.wdata;
        end
        return rdata;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ir <= '0;
        end else begin
            ir <= inst_i;
        end
    end

    assign op = opcode_e'(ir[31:26]);
    assign fn = funct_e'(ir[5:0]);
    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign rd = ir[15:11];
    assign sa = ir[10:6];

    always_comb begin
        alu_op    = ALU_NOP;
        alu_sel   = SEL_NOP;
        wd        = rd;    // rd unless an i-type
        wreg_base = 1'b0;
        re1       = 1'b0;
        re2       = 1'b0;
        imm       = '0;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    F_OR, F_AND, F_XOR, F_NOR: begin
                        if (sa == '0) begin
                            alu_sel   = SEL_LOGIC;
                            wreg_base = 1'b1;
                            re1       = 1'b1;
                            re2       = 1'b1;
                            case (fn)
                                F_OR:    alu_op = ALU_OR;
                                F_AND:   alu_op = ALU_AND;
                                F_XOR:   alu_op = ALU_XOR;
                                default: alu_op = ALU_NOR;
                            endcase
                        end
                    end
                    F_SLLV, F_SRLV, F_SRAV: begin
                        if (sa == '0) begin
                            alu_sel   = SEL_SHIFT;
                            wreg_base = 1'b1;
                            re1       = 1'b1; // amount from rs
                            re2       = 1'b1;
                            case (fn)
                                F_SLLV:  alu_op = ALU_SLL;
                                F_SRLV:  alu_op = ALU_SRL;
                                default: alu_op = ALU_SRA;
                            endcase
                        end
                    end
                    F_SLL, F_SRL, F_SRA: begin
                        // all-zero word is the canonical nop
                        if (rs == '0 && ir != '0) begin
                            alu_sel   = SEL_SHIFT;
                            wreg_base = 1'b1;
                            re2       = 1'b1;
                            imm       = {{(WORD_W-SHAMT_W){1'b0}}, sa}; // amount from sa
                            case (fn)
                                F_SLL:   alu_op = ALU_SLL;
                                F_SRL:   alu_op = ALU_SRL;
                                default: alu_op = ALU_SRA;
                            endcase
                        end
                    end
                    F_MFHI, F_MFLO: begin
                        alu_op    = (fn == F_MFHI) ? ALU_MFHI : ALU_MFLO;
                        alu_sel   = SEL_MOVE;
                        wreg_base = 1'b1;
                    end
                    F_MTHI, F_MTLO: begin
                        alu_op  = (fn == F_MTHI) ? ALU_MTHI : ALU_MTLO;
                        alu_sel = SEL_MOVE;
                        re1     = 1'b1;
                    end
                    F_MOVN, F_MOVZ: begin
                        alu_op  = (fn == F_MOVN) ? ALU_MOVN : ALU_MOVZ;
                        alu_sel = SEL_MOVE;
                        re1     = 1'b1;
                        re2     = 1'b1; // test operand
                    end
                    default: ;        // sync and unknown functs
                endcase
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                alu_sel   = SEL_LOGIC;
                wreg_base = 1'b1;
                re1       = 1'b1;
                wd        = rt;
                imm       = {{(WORD_W-IMM_W){1'b0}}, ir[IMM_W-1:0]};
                case (op)
                    OP_ORI:  alu_op = ALU_OR;
                    OP_ANDI: alu_op = ALU_AND;
                    default: alu_op = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                // both operands take the immediate, so or gives it back
                alu_op    = ALU_OR;
                alu_sel   = SEL_LOGIC;
                wreg_base = 1'b1;
                wd        = rt;
                imm       = {ir[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
            end
            OP_ADDI, OP_ADDIU: begin
                alu_op    = (op == OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
                alu_sel   = SEL_ARITH;
                wreg_base = 1'b1;
                re1       = 1'b1;
                wd        = rt;
                imm       = {{(WORD_W-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]}; // sign extend
            end
            default: ;                // pref and unsupported words
        endcase
    end

    assign op1 = resolve(re1, rs, rdata1_i, imm, ex_fwd_i, mem_fwd_i);
    assign op2 = resolve(re2, rt, rdata2_i, imm, ex_fwd_i, mem_fwd_i);

    always_comb begin
        wreg = wreg_base;
        if (alu_op == ALU_MOVN) begin
            wreg = (op2 != '0);
        end else if (alu_op == ALU_MOVZ) begin
            wreg = (op2 == '0);
        end
    end

    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign re1_o    = re1;
    assign re2_o    = re2;

    always_comb begin
        id_ex_o.alu_op  = alu_op;
        id_ex_o.alu_sel = alu_sel;
        id_ex_o.op1     = op1;
        id_ex_o.op2     = op2;
        id_ex_o.wd      = wd;
        id_ex_o.wreg    = wreg;
    end

    a_wreg_has_class: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        id_ex_o.wreg |-> id_ex_o.alu_sel != SEL_NOP);

endmodule

/* verilog/reg_file.sv */
module reg_file (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  isa_pkg::reg_addr_t raddr1_i,
    input  isa_pkg::reg_addr_t raddr2_i,
    input  logic               re1_i,
    input  logic               re2_i,
    output isa_pkg::word_t     rdata1_o,
    output isa_pkg::word_t     rdata2_o,
    input  pipe_pkg::wb_t      wb_i
);
    import isa_pkg::*;

    word_t regs [NUM_REGS];

    // r0 reads zero; a same-cycle write bypasses the array
    function automatic word_t read_port(input logic re, input reg_addr_t addr);
        if (!re || addr == '0) begin
            return '0;
        end else if (wb_i.wreg && wb_i.wd == addr) begin
            return wb_i.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wreg && wb_i.wd != '0) begin
            regs[wb_i.wd] <= wb_i.wdata;
        end
    end

    assign rdata1_o = read_port(re1_i, raddr1_i);
    assign rdata2_o = read_port(re2_i, raddr2_i);

    // holds even while r0 is the write target
    a_r0_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        regs[0] == '0);

endmodule

/* execute/execute.sv */
module execute (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  pipe_pkg::id_ex_t  id_ex_i,
    input  pipe_pkg::ex_res_t hilo_fwd_i, // ex_mem entry
    input  isa_pkg::word_t    hi_i,
    input  isa_pkg::word_t    lo_i,
    output pipe_pkg::ex_res_t ex_res_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    id_ex_t id_ex_q;
    word_t  hi_cur;
    word_t  lo_cur;
    word_t  logic_res;
    word_t  shift_res;
    word_t  move_res;
    word_t  arith_res;
    logic [SHAMT_W-1:0] shamt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_i;
        end
    end

    // ex_mem is one step ahead of the hi/lo registers
    assign hi_cur = (hilo_fwd_i.whilo) ? hilo_fwd_i.hi : hi_i;
    assign lo_cur = (hilo_fwd_i.whilo) ? hilo_fwd_i.lo : lo_i;
    assign shamt  = id_ex_q.op1[SHAMT_W-1:0];

    always_comb begin
        case (id_ex_q.alu_op)
            ALU_OR:  logic_res = id_ex_q.op1 | id_ex_q.op2;
            ALU_AND: logic_res = id_ex_q.op1 & id_ex_q.op2;
            ALU_XOR: logic_res = id_ex_q.op1 ^ id_ex_q.op2;
            ALU_NOR: logic_res = ~(id_ex_q.op1 | id_ex_q.op2);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_q.alu_op)
            ALU_SLL: shift_res = id_ex_q.op2 << shamt;
            ALU_SRL: shift_res = id_ex_q.op2 >> shamt;
            ALU_SRA: shift_res = word_t'($signed(id_ex_q.op2) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_q.alu_op)
            ALU_MFHI:           move_res = hi_cur;
            ALU_MFLO:           move_res = lo_cur;
            ALU_MOVN, ALU_MOVZ: move_res = id_ex_q.op1;
            default:            move_res = '0;
        endcase
    end

    assign arith_res = id_ex_q.op1 + id_ex_q.op2; // no overflow trap

    always_comb begin
        ex_res_o.wd    = id_ex_q.wd;
        ex_res_o.wreg  = id_ex_q.wreg;
        case (id_ex_q.alu_sel)
            SEL_LOGIC: ex_res_o.wdata = logic_res;
            SEL_SHIFT: ex_res_o.wdata = shift_res;
            SEL_MOVE:  ex_res_o.wdata = move_res;
            SEL_ARITH: ex_res_o.wdata = arith_res;
            default:   ex_res_o.wdata = '0;
        endcase
        ex_res_o.whilo = (id_ex_q.alu_op == ALU_MTHI) || (id_ex_q.alu_op == ALU_MTLO);
        ex_res_o.hi    = (id_ex_q.alu_op == ALU_MTHI) ? id_ex_q.op1 : hi_cur;
        ex_res_o.lo    = (id_ex_q.alu_op == ALU_MTLO) ? id_ex_q.op1 : lo_cur;
    end

    a_no_dual_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ex_res_o.whilo && ex_res_o.wreg));

endmodule

/* verilog/mem_wb_stage.sv */
module mem_wb_stage (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  pipe_pkg::ex_res_t ex_res_i,
    output pipe_pkg::ex_res_t ex_mem_o,
    output isa_pkg::word_t    hi_o,
    output isa_pkg::word_t    lo_o,
    output pipe_pkg::wb_t     wb_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ex_res_t ex_mem_q;
    wb_t     mem_wb_q;
    word_t   hi_q;
    word_t   lo_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            ex_mem_q       <= ex_res_i;
            mem_wb_q.wd    <= ex_mem_q.wd;
            mem_wb_q.wreg  <= ex_mem_q.wreg;
            mem_wb_q.wdata <= ex_mem_q.wdata;
        end
    end

    // hi/lo commit alongside the mem_wb load
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (ex_mem_q.whilo) begin
            hi_q <= ex_mem_q.hi;
            lo_q <= ex_mem_q.lo;
        end
    end

    assign ex_mem_o = ex_mem_q;
    assign hi_o     = hi_q;
    assign lo_o     = lo_q;
    assign wb_o     = mem_wb_q;

    a_hilo_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !ex_mem_q.whilo |=> $stable(hi_q) && $stable(lo_q));

endmodule

/* verilog/mips_core.sv */
module mips_core (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  isa_pkg::word_t     inst_i,
    output logic               wb_we_o,
    output isa_pkg::reg_addr_t wb_addr_o,
    output isa_pkg::word_t     wb_data_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      re1;
    logic      re2;
    word_t     rdata1;
    word_t     rdata2;
    word_t     hi;
    word_t     lo;
    id_ex_t    id_ex;
    ex_res_t   ex_res;   // also the execute forward
    ex_res_t   ex_mem;   // memory forward and hi/lo source
    wb_t       wb;

    instr_decode u_decode (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .inst_i    (inst_i),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_res),
        .mem_fwd_i (ex_mem),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .re1_o     (re1),
        .re2_o     (re2),
        .id_ex_o   (id_ex)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .re1_i    (re1),
        .re2_i    (re2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb)
    );

    execute u_execute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .hilo_fwd_i (ex_mem),
        .hi_i       (hi),
        .lo_i       (lo),
        .ex_res_o   (ex_res)
    );

    mem_wb_stage u_mem_wb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ex_res_i (ex_res),
        .ex_mem_o (ex_mem),
        .hi_o     (hi),
        .lo_o     (lo),
        .wb_o     (wb)
    );

    assign wb_we_o   = wb.wreg;
    assign wb_addr_o = wb.wd;
    assign wb_data_o = wb.wdata;

endmodule

/* verif/tb_mips_core.sv */
module tb_mips_core;
    import isa_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 3;
    localparam int    MAX_VEC      = 64;
    localparam int    FIELDS       = 4;            // inst, enable, address, data
    localparam int    WB_LATENCY   = 4;            // drive edge, then 3 pipeline edges
    localparam int    SLACK_CYCLES = 20;
    localparam word_t END_MARK     = 32'h0000_00ff; // enable column of the last record
    localparam string STIM_FILE    = "verif/core_stim.txt";

    logic      clk = 1'b0;
    logic      arst_n;
    word_t     inst;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t stim [MAX_VEC*FIELDS];
    int    num_vec;
    bit    stim_loaded = 1'b0;
    int    errors      = 0;
    int    checks      = 0;

    mips_core dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .inst_i    (inst),
        .wb_we_o   (wb_we),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // records run up to the end marker
    task automatic load_stim();
        num_vec = -1;
        $readmemh(STIM_FILE, stim);
        for (int i = 0; i < MAX_VEC; i++) begin
            if (num_vec < 0 && stim[FIELDS*i+1] == END_MARK) begin
                num_vec = i;
            end
        end
    endtask

    task automatic check_wb(input int idx);
        word_t exp_we;
        word_t exp_addr;
        word_t exp_data;
        exp_we   = stim[FIELDS*idx+1];
        exp_addr = stim[FIELDS*idx+2];
        exp_data = stim[FIELDS*idx+3];
        checks++;
        if (wb_we !== exp_we[0]) begin
            errors++;
            $display("[FAIL] t=%0t vec %0d wb_we_o expected %0b actual %0b",
                     $time, idx, exp_we[0], wb_we);
        end
        if (exp_we[0]) begin
            if (wb_addr !== exp_addr[4:0]) begin
                errors++;
                $display("[FAIL] t=%0t vec %0d wb_addr_o expected %0d actual %0d",
                         $time, idx, exp_addr[4:0], wb_addr);
            end
            if (wb_data !== exp_data) begin
                errors++;
                $display("[FAIL] t=%0t vec %0d wb_data_o expected %08h actual %08h",
                         $time, idx, exp_data, wb_data);
            end
        end
    endtask

    initial begin
        arst_n = 1'b0;
        inst   = '0;
        load_stim();
        if (num_vec < 0) begin
            errors++;
            $display("no end marker found in %s, nothing was run", STIM_FILE);
            num_vec = 0;
        end
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int c = 0; c < num_vec + WB_LATENCY; c++) begin
            @(posedge clk);
            if (c < num_vec) begin
                inst <= stim[FIELDS*c];
            end else begin
                inst <= '0;                   // nop padding
            end
            @(negedge clk);
            if (c >= WB_LATENCY) begin
                check_wb(c - WB_LATENCY);     // result of the word driven 4 edges ago
            end
        end
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (stim_loaded);
        #((num_vec + SLACK_CYCLES) * CLK_PERIOD);
        $display("watchdog timeout, run did not finish within %0d cycles",
                 num_vec + SLACK_CYCLES);
        $display("errors: %0d in %0d checks", errors + 1, checks);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verif/core_stim.txt */
// columns: instruction, expected wb_we_o, expected wb_addr_o, expected wb_data_o (hex)
// a record with ff in the enable column ends the list
34011234 1 01 00001234 // ori   r1, r0, 0x1234
3c02a5f0 1 02 a5f00000 // lui   r2, 0xa5f0
34438001 1 03 a5f08001 // ori   r3, r2, 0x8001
3064ff0f 1 04 00008001 // andi  r4, r3, 0xff0f
3825ffff 1 05 0000edcb // xori  r5, r1, 0xffff
00223025 1 06 a5f01234 // or    r6, r1, r2
00c33824 1 07 a5f00000 // and   r7, r6, r3
00c74026 1 08 00001234 // xor   r8, r6, r7
00054827 1 09 ffff1234 // nor   r9, r0, r5
00095100 1 0a fff12340 // sll   r10, r9, 4
00095a02 1 0b 00ffff12 // srl   r11, r9, 8
00096203 1 0c ffffff12 // sra   r12, r9, 8
00236804 1 0d 00100000 // sllv  r13, r3, r1
01027006 1 0e 00000a5f // srlv  r14, r2, r8
01027807 1 0f fffffa5f // srav  r15, r2, r8
24100010 1 10 00000010 // addiu r16, r0, 0x10
26110007 1 11 00000017 // addiu r17, r16, 7
02119026 1 12 00000007 // xor   r18, r16, r17
02129826 1 13 00000017 // xor   r19, r16, r18
26140001 1 14 00000011 // addiu r20, r16, 1
00600011 0 00 00000000 // mthi  r3
0000a810 1 15 a5f08001 // mfhi  r21
02800013 0 00 00000000 // mtlo  r20
00000000 0 00 00000000 // nop
0000b012 1 16 00000011 // mflo  r22
0000b810 1 17 a5f08001 // mfhi  r23
00c00013 0 00 00000000 // mtlo  r6
0000c012 1 18 a5f01234 // mflo  r24
0020c80b 0 00 00000000 // movn  r25, r1, r0
0024c80b 1 19 00001234 // movn  r25, r1, r4
0040d00a 1 1a a5f00000 // movz  r26, r2, r0
003ad00a 0 00 00000000 // movz  r26, r1, r26
201bfff0 1 1b fffffff0 // addi  r27, r0, -16
277c8000 1 1c ffff7ff0 // addiu r28, r27, 0x8000
239d7fff 1 1d ffffffef // addi  r29, r28, 0x7fff
0000000f 0 00 00000000 // sync
cc220004 0 00 00000000 // pref
342000ff 1 00 000012ff // ori   r0, r1, 0xff
0000f025 1 1e 00000000 // or    r30, r0, r0
fc43ffff 0 00 00000000 // unsupported opcode
0022f820 0 00 00000000 // add, unsupported funct
0006f825 1 1f a5f01234 // or    r31, r0, r6
0000f810 1 1f a5f08001 // mfhi  r31
033a1825 1 03 a5f01234 // or    r3, r25, r26
ffffffff ff ff ffffffff // end of list

/* mips_core.f */
common/isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decode.sv
verilog/reg_file.sv
execute/execute.sv
verilog/mem_wb_stage.sv
verilog/mips_core.sv
verif/tb_mips_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mips_core
LINT_TOP   := mips_core
FILELIST   := mips_core.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
